//--- source/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`default_nettype none

//////////////////////////////////////////////////
// Datapath sizing
//////////////////////////////////////////////////
`define WORD_W      32          // Data word width
`define REG_NUM     32          // GPR count, x0 included
`define RESET_PC    32'h0000_0000 // First expected PC

//////////////////////////////////////////////////
// Exception codes carried in the retire record
//////////////////////////////////////////////////
`define EXP_NONE    2'd0        // Normal retire
`define EXP_ILLEGAL 2'd1        // Unknown opcode or funct3

`default_nettype wire

`endif

//--- source/core_pkg.sv
`default_nettype none

`include "core_settings.svh"

package core_pkg;

    typedef logic [`WORD_W-1:0]          word_t;      // Data word
    typedef logic [$clog2(`REG_NUM)-1:0] reg_addr_t;  // GPR index
    typedef logic [1:0]                  exp_code_t;  // Exception code

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_NONE, CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU, CMP_ALWAYS
    } cmp_op_e;

    typedef enum logic {
        OUT_ALU,                // ALU result
        OUT_LINK                // PC+4 for JAL/JALR
    } out_sel_e;

    //////////////////////////////////////////////////
    // Pipeline bundles
    //////////////////////////////////////////////////
    typedef struct packed {
        logic      valid;       // Real instruction, not a bubble
        word_t     pc;
        alu_op_e   alu_op;
        word_t     alu_in_0;    // Also JALR target base
        word_t     alu_in_1;
        cmp_op_e   cmp_op;
        word_t     cmp_in_0;
        word_t     cmp_in_1;
        reg_addr_t rd_addr;
        logic      gpr_we;
        out_sel_e  out_sel;
        exp_code_t exp_code;
        logic      is_jalr;
        word_t     jump_offset; // Branch/JAL/JALR immediate
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd_addr;
        logic      gpr_we;
        word_t     data;        // Value for rd
        exp_code_t exp_code;
        logic      redirect;    // Taken branch or jump
        word_t     target;
    } ex_wb_t;

    // Empty slot: no write, no compare, add of zeros
    localparam id_ex_t ID_EX_BUBBLE = '{
        valid: 1'b0, pc: '0, alu_op: ALU_ADD, alu_in_0: '0, alu_in_1: '0,
        cmp_op: CMP_NONE, cmp_in_0: '0, cmp_in_1: '0, rd_addr: '0,
        gpr_we: 1'b0, out_sel: OUT_ALU, exp_code: `EXP_NONE,
        is_jalr: 1'b0, jump_offset: '0
    };

endpackage

`default_nettype wire

//--- source/gpr_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module gpr_file import core_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire reg_addr_t rs1_addr,
    input  wire reg_addr_t rs2_addr,
    input  wire        we,
    input  wire reg_addr_t wr_addr,
    input  wire word_t wr_data,
    output word_t      rs1_data,
    output word_t      rs2_data
);

    word_t regs [`REG_NUM];     // x0 never written

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data; // Writes to x0 dropped
        end
    end

    // Old value during a write, bypass in the decoder covers it
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- source/rv_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module rv_decoder import core_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         in_valid,
    input  wire word_t  in_instr,
    input  wire word_t  in_pc,
    input  wire         wb_ready,
    input  wire ex_wb_t ex_fwd,     // Result now in execute
    input  wire ex_wb_t wb_fwd,     // Result held in writeback
    input  wire word_t  rs1_data,
    input  wire word_t  rs2_data,
    output reg_addr_t   rs1_addr,
    output reg_addr_t   rs2_addr,
    output logic        in_ready,
    output id_ex_t      bundle
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    word_t      expected_pc;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;            // funct7 bit 5, SUB/SRA select
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    word_t      rs1_val;
    word_t      rs2_val;
    logic       accept;
    logic       pc_match;
    id_ex_t     dec;

    // Execute first, then writeback, then register file
    function automatic word_t bypass(reg_addr_t addr, word_t gpr, ex_wb_t ex_r, ex_wb_t wb_r);
        word_t val;
        val = gpr;
        if (wb_r.valid && wb_r.gpr_we && (wb_r.rd_addr == addr)) val = wb_r.data;
        if (ex_r.valid && ex_r.gpr_we && (ex_r.rd_addr == addr)) val = ex_r.data;
        if (addr == '0) val = '0;
        return val;
    endfunction

    function automatic alu_op_e alu_sel(logic [2:0] f3, logic f7_alt, logic is_reg);
        case (f3)
            3'b000:  return (is_reg && f7_alt) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return f7_alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode   = in_instr[6:0];
    assign funct3   = in_instr[14:12];
    assign alt      = in_instr[30];
    assign rs1_addr = in_instr[19:15];
    assign rs2_addr = in_instr[24:20];

    assign imm_i = {{20{in_instr[31]}}, in_instr[31:20]};
    assign imm_u = {in_instr[31:12], 12'b0};
    assign imm_b = {{19{in_instr[31]}}, in_instr[31], in_instr[7], in_instr[30:25],
                    in_instr[11:8], 1'b0};
    assign imm_j = {{11{in_instr[31]}}, in_instr[31], in_instr[19:12], in_instr[20],
                    in_instr[30:21], 1'b0};

    assign rs1_val = bypass(rs1_addr, rs1_data, ex_fwd, wb_fwd);
    assign rs2_val = bypass(rs2_addr, rs2_data, ex_fwd, wb_fwd);

    assign in_ready = wb_ready;              // Stall blocks intake
    assign accept   = in_valid && wb_ready;
    assign pc_match = (in_pc == expected_pc);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            expected_pc <= `RESET_PC;
        end else if (ex_fwd.redirect) begin
            expected_pc <= ex_fwd.target;      // Branch wins over intake
        end else if (accept && pc_match) begin
            expected_pc <= in_pc + 32'd4;
        end
    end

    always_comb begin
        dec         = ID_EX_BUBBLE;
        dec.valid   = 1'b1;
        dec.pc      = in_pc;
        dec.rd_addr = in_instr[11:7];
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                dec.alu_op   = alu_sel(funct3, alt, opcode == OPC_OP);
                dec.alu_in_0 = rs1_val;
                dec.alu_in_1 = (opcode == OPC_OP) ? rs2_val : imm_i;
                dec.gpr_we   = 1'b1;
            end
            OPC_LUI: begin
                dec.alu_op   = ALU_PASS_B;
                dec.alu_in_1 = imm_u;
                dec.gpr_we   = 1'b1;
            end
            OPC_AUIPC: begin
                dec.alu_in_0 = in_pc;        // ADD of pc and upper imm
                dec.alu_in_1 = imm_u;
                dec.gpr_we   = 1'b1;
            end
            OPC_BRANCH: begin
                dec.cmp_in_0    = rs1_val;
                dec.cmp_in_1    = rs2_val;
                dec.jump_offset = imm_b;
                case (funct3)
                    3'b000:  dec.cmp_op = CMP_EQ;
                    3'b001:  dec.cmp_op = CMP_NE;
                    3'b100:  dec.cmp_op = CMP_LT;
                    3'b101:  dec.cmp_op = CMP_GE;
                    3'b110:  dec.cmp_op = CMP_LTU;
                    3'b111:  dec.cmp_op = CMP_GEU;
                    default: dec.exp_code = `EXP_ILLEGAL;
                endcase
            end
            OPC_JAL: begin
                dec.alu_in_0    = in_pc;
                dec.cmp_op      = CMP_ALWAYS;
                dec.jump_offset = imm_j;
                dec.out_sel     = OUT_LINK;
                dec.gpr_we      = 1'b1;
            end
            OPC_JALR: begin
                dec.alu_in_0    = rs1_val;   // Target base
                dec.cmp_op      = CMP_ALWAYS;
                dec.jump_offset = imm_i;
                dec.out_sel     = OUT_LINK;
                dec.gpr_we      = 1'b1;
                dec.is_jalr     = 1'b1;
                if (funct3 != 3'b000) begin
                    dec         = ID_EX_BUBBLE;
                    dec.valid   = 1'b1;
                    dec.pc      = in_pc;
                    dec.rd_addr = in_instr[11:7];
                    dec.exp_code = `EXP_ILLEGAL;
                end
            end
            default: dec.exp_code = `EXP_ILLEGAL; // Retires without write
        endcase
    end

    // Wrong-PC or idle slot becomes a bubble
    assign bundle = (accept && pc_match) ? dec : ID_EX_BUBBLE;

endmodule

`default_nettype wire

//--- source/id_ex_reg.sv
`timescale 1ns/100ps
`default_nettype none

module id_ex_reg import core_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         stall,      // Writeback full
    input  wire         flush,      // Redirect from execute
    input  wire id_ex_t bundle_in,
    output id_ex_t      bundle_out
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bundle_out <= ID_EX_BUBBLE;
        end else if (!stall) begin       // Flush waits out a stall
            if (flush) begin
                bundle_out <= ID_EX_BUBBLE;  // Drop wrong-path slot
            end else begin
                bundle_out <= bundle_in;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/ex_unit.sv
`timescale 1ns/100ps
`default_nettype none

module ex_unit import core_pkg::*; (
    input  wire id_ex_t bundle,
    input  wire         wb_ready,
    output ex_wb_t      result,
    output logic        redirect,
    output word_t       redirect_target
);

    word_t alu_a;
    word_t alu_b;
    word_t alu_y;
    word_t target_sum;
    logic  taken;

    assign alu_a = bundle.alu_in_0;
    assign alu_b = bundle.alu_in_1;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////
    always_comb begin
        case (bundle.alu_op)
            ALU_ADD:  alu_y = alu_a + alu_b;
            ALU_SUB:  alu_y = alu_a - alu_b;
            ALU_SLL:  alu_y = alu_a << alu_b[4:0];       // Shamt low 5 bits
            ALU_SLT:  alu_y = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_y = {31'b0, alu_a < alu_b};
            ALU_XOR:  alu_y = alu_a ^ alu_b;
            ALU_SRL:  alu_y = alu_a >> alu_b[4:0];
            ALU_SRA:  alu_y = word_t'($signed(alu_a) >>> alu_b[4:0]);
            ALU_OR:   alu_y = alu_a | alu_b;
            ALU_AND:  alu_y = alu_a & alu_b;
            default:  alu_y = alu_b;                      // LUI
        endcase
    end

    //////////////////////////////////////////////////
    // Branch compare and target
    //////////////////////////////////////////////////
    always_comb begin
        case (bundle.cmp_op)
            CMP_EQ:     taken = (bundle.cmp_in_0 == bundle.cmp_in_1);
            CMP_NE:     taken = (bundle.cmp_in_0 != bundle.cmp_in_1);
            CMP_LT:     taken = ($signed(bundle.cmp_in_0) < $signed(bundle.cmp_in_1));
            CMP_GE:     taken = ($signed(bundle.cmp_in_0) >= $signed(bundle.cmp_in_1));
            CMP_LTU:    taken = (bundle.cmp_in_0 < bundle.cmp_in_1);
            CMP_GEU:    taken = (bundle.cmp_in_0 >= bundle.cmp_in_1);
            CMP_ALWAYS: taken = 1'b1;                     // JAL/JALR
            default:    taken = 1'b0;
        endcase
    end

    assign target_sum = (bundle.is_jalr ? alu_a : bundle.pc) + bundle.jump_offset;
    assign redirect_target = {target_sum[31:1], target_sum[0] & ~bundle.is_jalr};

    // Held branch fires only when writeback takes it
    assign redirect = bundle.valid && taken && wb_ready;

    always_comb begin
        result.valid    = bundle.valid;
        result.pc       = bundle.pc;
        result.rd_addr  = bundle.rd_addr;
        result.gpr_we   = bundle.gpr_we;
        result.data     = (bundle.out_sel == OUT_LINK) ? bundle.pc + 32'd4 : alu_y;
        result.exp_code = bundle.exp_code;
        result.redirect = redirect;
        result.target   = redirect_target;
    end

endmodule

`default_nettype wire

//--- source/wb_stage.sv
`timescale 1ns/100ps
`default_nettype none

module wb_stage import core_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire ex_wb_t result,
    input  wire         retire_ready,
    output logic        wb_ready,
    output logic        retire_valid,
    output ex_wb_t      retire_rec,
    output logic        gpr_we,
    output reg_addr_t   gpr_wr_addr,
    output word_t       gpr_wr_data,
    output ex_wb_t      wb_fwd
);

    ex_wb_t rec_q;                  // Record offered on retire port
    logic   retire_fire;

    assign wb_ready    = !rec_q.valid || retire_ready;    // Empty or draining
    assign retire_fire = rec_q.valid && retire_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rec_q <= '0;
        end else if (wb_ready) begin
            rec_q <= result;        // Bubbles load with valid low
        end
    end

    assign retire_valid = rec_q.valid;
    assign retire_rec   = rec_q;
    assign wb_fwd       = rec_q;    // Not yet in the register file

    // Register write on the handshake edge only
    assign gpr_we      = retire_fire && rec_q.gpr_we && (rec_q.rd_addr != '0);
    assign gpr_wr_addr = rec_q.rd_addr;
    assign gpr_wr_data = rec_q.data;

endmodule

`default_nettype wire

//--- source/exec_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module exec_core_top import core_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        in_valid,
    input  wire word_t in_instr,
    input  wire word_t in_pc,
    output logic       in_ready,
    output logic       retire_valid,
    output ex_wb_t     retire_rec,
    input  wire        retire_ready
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      gpr_we;
    reg_addr_t gpr_wr_addr;
    word_t     gpr_wr_data;
    id_ex_t    dec_bundle;          // Decoder to ID/EX
    id_ex_t    ex_bundle;           // ID/EX to execute
    ex_wb_t    ex_result;
    ex_wb_t    wb_fwd;
    logic      wb_ready;
    logic      redirect;

    gpr_file gpr_file_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .we       (gpr_we),
        .wr_addr  (gpr_wr_addr),
        .wr_data  (gpr_wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_decoder rv_decoder_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_pc    (in_pc),
        .wb_ready (wb_ready),
        .ex_fwd   (ex_result),      // Carries redirect and target too
        .wb_fwd   (wb_fwd),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .in_ready (in_ready),
        .bundle   (dec_bundle)
    );

    id_ex_reg id_ex_reg_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (!wb_ready),
        .flush      (redirect),
        .bundle_in  (dec_bundle),
        .bundle_out (ex_bundle)
    );

    ex_unit ex_unit_inst (
        .bundle          (ex_bundle),
        .wb_ready        (wb_ready),
        .result          (ex_result),
        .redirect        (redirect),
        .redirect_target ()         // Target reaches the decoder inside ex_result
    );

    wb_stage wb_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .result       (ex_result),
        .retire_ready (retire_ready),
        .wb_ready     (wb_ready),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec),
        .gpr_we       (gpr_we),
        .gpr_wr_addr  (gpr_wr_addr),
        .gpr_wr_data  (gpr_wr_data),
        .wb_fwd       (wb_fwd)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 8         // Full clock period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;                     // Starts low, first rise at half period
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- dv/exec_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exec_core_tb import core_pkg::*; ();

    localparam int NUM_LINES    = 19;   // Instructions in the pattern file
    localparam int LINE_WORDS   = 8;    // Columns per pattern line
    localparam int CLK_NS       = 8;
    localparam int RESET_CYCLES = 5;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + 20 * NUM_LINES) * CLK_NS;
    localparam logic [31:0] SEED = 32'hd74e3b88;

    // Column offsets within one line
    localparam int COL_INSTR  = 0;
    localparam int COL_PC     = 1;
    localparam int COL_FLAG   = 2;      // Bit 0 retires, bit 1 writes rd
    localparam int COL_RD     = 3;
    localparam int COL_DATA   = 4;
    localparam int COL_EXP    = 5;
    localparam int COL_REDIR  = 6;
    localparam int COL_TARGET = 7;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    word_t  in_instr;
    word_t  in_pc;
    logic   in_ready;
    logic   retire_valid;
    ex_wb_t retire_rec;
    logic   retire_ready;

    logic [31:0] pattern_mem [NUM_LINES * LINE_WORDS];
    int          issue_idx;             // Next line offered to the DUT
    int          expect_idx;            // Next line a retire must match
    int          retired_cnt;

    tb_clock_gen #(.PERIOD_NS(CLK_NS)) tb_clock_gen_inst (.clk(clk));

    exec_core_top exec_core_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_instr     (in_instr),
        .in_pc        (in_pc),
        .in_ready     (in_ready),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec),
        .retire_ready (retire_ready)
    );

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
            $display("Checks failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Skips wrong-path and squashed lines
    function automatic int next_expected(input int from);
        int idx;
        idx = from;
        while ((idx < NUM_LINES) && !pattern_mem[idx * LINE_WORDS + COL_FLAG][0]) begin
            idx++;
        end
        return idx;
    endfunction

    task automatic compare_record();
        int          base;
        logic [31:0] flag;
        if (expect_idx >= NUM_LINES) begin
            $display("Unexpected retire of a record with pc %h at time %0t", retire_rec.pc, $time);
            $display("Checks failed");
            $fatal(1, "Extra record on the retire port");
        end else begin
            base = expect_idx * LINE_WORDS;
            flag = pattern_mem[base + COL_FLAG];
            check_value("retire_rec.valid", {31'b0, retire_rec.valid}, 32'd1);
            check_value("retire_rec.pc", retire_rec.pc, pattern_mem[base + COL_PC]);
            check_value("retire_rec.gpr_we", {31'b0, retire_rec.gpr_we}, {31'b0, flag[1]});
            check_value("retire_rec.exp_code", {30'b0, retire_rec.exp_code},
                        pattern_mem[base + COL_EXP]);
            check_value("retire_rec.redirect", {31'b0, retire_rec.redirect},
                        pattern_mem[base + COL_REDIR]);
            if (flag[1]) begin                      // Register writers only
                check_value("retire_rec.rd_addr", {27'b0, retire_rec.rd_addr},
                            pattern_mem[base + COL_RD]);
                check_value("retire_rec.data", retire_rec.data, pattern_mem[base + COL_DATA]);
            end
            if (pattern_mem[base + COL_REDIR][0]) begin
                check_value("retire_rec.target", retire_rec.target,
                            pattern_mem[base + COL_TARGET]);
            end
            retired_cnt++;
            expect_idx = next_expected(expect_idx + 1);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    task automatic drive_inputs(input logic hold_instr);
        int base;
        base = issue_idx * LINE_WORDS;
        if (!hold_instr) begin                      // Offered word stays until taken
            if ((issue_idx < NUM_LINES) && (($urandom % 32'd4) != 32'd0)) begin
                in_valid <= 1'b1;
                in_instr <= pattern_mem[base + COL_INSTR];
                in_pc    <= pattern_mem[base + COL_PC];
            end else begin
                in_valid <= 1'b0;                   // Random gap
            end
        end
        retire_ready <= (($urandom % 32'd4) != 32'd0); // Back-pressure about 1 in 4
    endtask

    // Sample mid-cycle, drive on the rising edge
    task automatic step_cycle();
        logic took_instr;
        logic hold_instr;
        @(negedge clk);
        took_instr = in_valid && in_ready;
        hold_instr = in_valid && !in_ready;
        if (retire_valid && retire_ready) begin
            compare_record();
        end
        @(posedge clk);
        if (took_instr) begin
            issue_idx++;
        end
        drive_inputs(hold_instr);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_instr     = '0;
        in_pc        = '0;
        retire_ready = 1'b0;
        issue_idx    = 0;
        retired_cnt  = 0;
        $readmemh("dv/exec_patterns.hex", pattern_mem);
        expect_idx   = next_expected(0);

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_value("retire_valid", {31'b0, retire_valid}, 32'd0); // Empty after reset
        check_value("in_ready", {31'b0, in_ready}, 32'd1);
        @(posedge clk);
        rst_n <= 1'b1;

        while ((expect_idx < NUM_LINES) || (issue_idx < NUM_LINES)) begin
            step_cycle();
        end
        repeat (6) begin
            step_cycle();                           // Stray retires fail here
        end

        $display("Retired %0d records", retired_cnt);
        $display("All checks passed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns with %0d records retired", WATCHDOG_NS, retired_cnt);
        $display("Checks failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

//--- dv/exec_patterns.hex
// instr pc flag rd data exp_code redirect target
// flag bit 0 = record retires, bit 1 = rd and data checked
800000B7 00000000 3 01 80000000 0 0 00000000 // lui x1, 0x80000
FFB00113 00000004 3 02 FFFFFFFB 0 0 00000000 // addi x2, x0, -5
4020D1B3 00000008 3 03 FFFFFFF0 0 0 00000000 // sra x3, x1, x2
40218233 0000000C 3 04 FFFFFFF5 0 0 00000000 // sub x4, x3, x2
002232B3 00000010 3 05 00000001 0 0 00000000 // sltu x5, x4, x2
12345317 00000014 3 06 12345014 0 0 00000000 // auipc x6, 0x12345
00029663 00000018 1 00 00000000 0 1 00000024 // bne x5, x0, +12 taken
00100393 0000001C 0 07 00000001 0 0 00000000 // wrong path
00200413 00000020 0 08 00000002 0 0 00000000 // wrong path
00C004EF 00000024 3 09 00000028 0 1 00000030 // jal x9, +12
00100393 00000028 0 07 00000001 0 0 00000000 // wrong path
00200413 0000002C 0 08 00000002 0 0 00000000 // wrong path
01548567 00000030 3 0A 00000034 0 1 0000003C // jalr x10, 0x15(x9)
00100393 00000034 0 07 00000001 0 0 00000000 // wrong path
00200413 00000038 0 08 00000002 0 0 00000000 // wrong path
0000020B 0000003C 1 04 00000000 1 0 00000000 // unknown opcode, rd x4
00020593 00000040 3 0B FFFFFFF5 0 0 00000000 // addi x11, x4, 0
00B04463 00000044 1 00 00000000 0 0 00000000 // blt x0, x11 not taken
0FF5C613 00000048 3 0C FFFFFF0A 0 0 00000000 // xori x12, x11, 0xff

//--- src.f
+incdir+source
source/core_pkg.sv
source/gpr_file.sv
source/rv_decoder.sv
source/id_ex_reg.sv
source/ex_unit.sv
source/wb_stage.sv
source/exec_core_top.sv
dv/tb_clock_gen.sv
dv/exec_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module exec_core_tb -o exec_core_sim \
    && ./obj_dir/exec_core_sim | tee /dev/stderr | grep -q "All checks passed" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
